// ==== logic/bp_pkg.sv ====
`default_nettype none

////////////////////////////////////////
// shared types for the fetch predictor
////////////////////////////////////////

package bp_pkg;

    // pc is a word address, byte offset dropped
    localparam int pc_width = 30;

    typedef logic [pc_width-1:0] pc_t; // pc, target and next pc

    // branch kinds as stored in the btb
    typedef enum logic [1:0] {
        br_none = 2'd0, // miss or not a branch
        br_cond = 2'd1, // conditional, decided by pht
        br_jump = 2'd2, // unconditional direct jump
        br_call = 2'd3  // call, always taken
    } br_type_e;

    // 2-bit saturating counter
    // 0,1 predict not taken and 2,3 predict taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_min         = 2'd0; // strongly not taken
    localparam ctr_t ctr_max         = 2'd3; // strongly taken
    localparam ctr_t ctr_reset_value = 2'd1; // weakly not taken

endpackage

`default_nettype wire

// ==== logic/bp_update_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// resolved branch update from execute
// single-cycle strobe on valid with no handshake
interface bp_update_if;

    logic              valid;   // update strobe
    bp_pkg::pc_t       pc;      // pc of the resolved branch
    bp_pkg::br_type_e  br_type; // never br_none when valid
    bp_pkg::pc_t       target;  // resolved target
    logic              taken;   // resolved direction

    // driver side, top level
    modport source (
        output valid,
        output pc,
        output br_type,
        output target,
        output taken
    );

    // btb and pht
    modport sink (
        input valid,
        input pc,
        input br_type,
        input target,
        input taken
    );

endinterface

`default_nettype wire

// ==== logic/sdp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// simple dual-port ram
// one write port and one registered read port on the same clock
module sdp_ram #(
    parameter int width = 8,
    parameter int depth = 128
) (
    input  wire                     clk,
    // write port
    input  wire                     we,
    input  wire [$clog2(depth)-1:0] waddr,
    input  wire [width-1:0]         wdata,
    // read port
    input  wire [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]        rdata
);

    // storage, no init
    logic [width-1:0] mem [depth];

    ////////////////////////////////////////
    // write
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // read
    ////////////////////////////////////////

    // nonblocking read picks up pre-write data on a collision
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== logic/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

// direct-mapped branch target buffer
// index is the low pc bits and tag the rest
module btb #(
    parameter int btb_depth = 128
) (
    input  wire               clk,
    input  wire               rstn,
    // lookup
    input  wire bp_pkg::pc_t  pc,
    output logic              hit,
    output bp_pkg::br_type_e  hit_type,
    output bp_pkg::pc_t       hit_target,
    // training
    bp_update_if.sink         upd
);

    localparam int idx_w = $clog2(btb_depth);
    localparam int tag_w = bp_pkg::pc_width - idx_w;

    logic [btb_depth-1:0] valid;     // one bit per entry
    logic                 valid_q;   // valid bit of the looked up entry
    bp_pkg::pc_t          pc_q;      // lookup pc, lines up with ram read

    logic [tag_w-1:0]     tag_rd;    // stored tag
    logic [1:0]           type_rd;   // stored branch kind
    bp_pkg::pc_t          target_rd; // stored target

    wire [idx_w-1:0] rd_idx = pc[idx_w-1:0];
    wire [idx_w-1:0] wr_idx = upd.pc[idx_w-1:0];

    ////////////////////////////////////////
    // valid bits and lookup registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            valid   <= '0; // empty table
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= valid[rd_idx]; // old value on same-edge write
            if (upd.valid)
            begin
                valid[wr_idx] <= 1'b1;
            end
        end
    end

    // payload register beside the ram outputs
    always_ff @(posedge clk)
    begin
        pc_q <= pc;
    end

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    sdp_ram #(
        .width (tag_w),
        .depth (btb_depth)
    ) i_tag_ram (
        .clk   (clk),
        .we    (upd.valid),
        .waddr (wr_idx),
        .wdata (upd.pc[bp_pkg::pc_width-1:idx_w]), // upper pc bits
        .raddr (rd_idx),
        .rdata (tag_rd)
    );

    sdp_ram #(
        .width (2),
        .depth (btb_depth)
    ) i_type_ram (
        .clk   (clk),
        .we    (upd.valid),
        .waddr (wr_idx),
        .wdata (upd.br_type),
        .raddr (rd_idx),
        .rdata (type_rd)
    );

    sdp_ram #(
        .width (bp_pkg::pc_width),
        .depth (btb_depth)
    ) i_target_ram (
        .clk   (clk),
        .we    (upd.valid),
        .waddr (wr_idx),
        .wdata (upd.target),
        .raddr (rd_idx),
        .rdata (target_rd)
    );

    ////////////////////////////////////////
    // hit check
    ////////////////////////////////////////

    // tag compare against the registered pc
    assign hit = valid_q && (tag_rd == pc_q[bp_pkg::pc_width-1:idx_w]);

    // miss reads as not a branch
    assign hit_type   = hit ? bp_pkg::br_type_e'(type_rd) : bp_pkg::br_none;
    assign hit_target = hit ? target_rd : pc_q; // fall back to lookup pc

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // execute only reports real branches
    a_upd_not_none : assert property (
        @(posedge clk) disable iff (!rstn)
        upd.valid |-> (upd.br_type != bp_pkg::br_none)
    );

    // a live entry always holds a real branch kind
    a_hit_typed : assert property (
        @(posedge clk) disable iff (!rstn)
        hit |-> (hit_type != bp_pkg::br_none)
    );

endmodule

`default_nettype wire

// ==== logic/pht.sv ====
`timescale 1ns/1ps
`default_nettype none

// pattern history table
// 2-bit saturating counters in flops indexed by low pc bits
module pht #(
    parameter int pht_depth = 256
) (
    input  wire               clk,
    input  wire               rstn,
    // lookup
    input  wire bp_pkg::pc_t  pc,
    output bp_pkg::ctr_t      ctr, // counter for the registered pc
    // training
    bp_update_if.sink         upd
);

    localparam int idx_w = $clog2(pht_depth);

    bp_pkg::ctr_t counters [pht_depth];

    wire [idx_w-1:0] rd_idx = pc[idx_w-1:0];
    wire [idx_w-1:0] wr_idx = upd.pc[idx_w-1:0];

    // only conditional branches train
    wire train = upd.valid && (upd.br_type == bp_pkg::br_cond);

    ////////////////////////////////////////
    // counters and read register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < pht_depth; i++)
            begin
                counters[i] <= bp_pkg::ctr_reset_value; // weakly not taken
            end
            ctr <= bp_pkg::ctr_reset_value;
        end
        else
        begin
            ctr <= counters[rd_idx]; // pre-update value on same edge
            if (train)
            begin
                if (upd.taken)
                begin
                    if (counters[wr_idx] != bp_pkg::ctr_max)
                    begin
                        counters[wr_idx] <= counters[wr_idx] + 2'd1; // count up
                    end
                end
                else
                begin
                    if (counters[wr_idx] != bp_pkg::ctr_min)
                    begin
                        counters[wr_idx] <= counters[wr_idx] - 2'd1; // count down
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a known pc always reads back a known counter
    a_ctr_known : assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(pc) |=> !$isunknown(ctr)
    );

endmodule

`default_nettype wire

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

// fetch-stage branch predictor
// btb gives kind and target, pht decides conditionals
module branch_predictor #(
    parameter int btb_depth = 128,
    parameter int pht_depth = 256
) (
    input  wire                    clk,
    input  wire                    rstn,
    // fetch side
    input  wire bp_pkg::pc_t       fetch_pc,
    // resolved branch from execute
    input  wire                    update_valid,
    input  wire bp_pkg::pc_t       update_pc,
    input  wire bp_pkg::br_type_e  update_br_type,
    input  wire bp_pkg::pc_t       update_target,
    input  wire                    update_taken,
    // prediction, one cycle after fetch_pc
    output bp_pkg::br_type_e       pred_type,
    output logic                   pred_taken,
    output bp_pkg::pc_t            pred_target,
    output bp_pkg::pc_t            next_pc
);

    logic              hit;
    bp_pkg::br_type_e  hit_type;
    bp_pkg::pc_t       hit_target;
    bp_pkg::ctr_t      ctr;
    bp_pkg::pc_t       fall_pc;  // lookup pc, aligned with btb output

    ////////////////////////////////////////
    // update bus
    ////////////////////////////////////////

    bp_update_if upd_bus ();

    assign upd_bus.valid   = update_valid;
    assign upd_bus.pc      = update_pc;
    assign upd_bus.br_type = update_br_type;
    assign upd_bus.target  = update_target;
    assign upd_bus.taken   = update_taken;

    ////////////////////////////////////////
    // tables
    ////////////////////////////////////////

    btb #(
        .btb_depth (btb_depth)
    ) i_btb (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (fetch_pc),
        .hit        (hit),
        .hit_type   (hit_type),
        .hit_target (hit_target),
        .upd        (upd_bus)
    );

    pht #(
        .pht_depth (pht_depth)
    ) i_pht (
        .clk  (clk),
        .rstn (rstn),
        .pc   (fetch_pc),
        .ctr  (ctr),
        .upd  (upd_bus)
    );

    // needed on a conditional hit that falls through
    always_ff @(posedge clk)
    begin
        fall_pc <= fetch_pc;
    end

    ////////////////////////////////////////
    // decision
    ////////////////////////////////////////

    always_comb
    begin
        case (hit_type)
            bp_pkg::br_jump, bp_pkg::br_call: pred_taken = hit;          // always taken
            bp_pkg::br_cond:                  pred_taken = hit && ctr[1]; // msb is direction
            default:                          pred_taken = 1'b0;
        endcase
    end

    assign pred_type   = hit_type;
    assign pred_target = hit_target; // lookup pc on a miss
    assign next_pc     = pred_taken ? hit_target : fall_pc + bp_pkg::pc_t'(1);

endmodule

`default_nettype wire

// ==== verif/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the fetch branch predictor
// records come from verif/bp_tests.txt, one per line
module tb_branch_predictor;

    localparam int btb_depth     = 128;  // dut defaults
    localparam int pht_depth     = 256;
    localparam int max_lines     = 1000; // bound on the file loop
    localparam int reset_timeout = 20;   // cycles to see rstn high

    logic              clk;
    logic              rstn;
    bp_pkg::pc_t       fetch_pc;
    logic              update_valid;
    bp_pkg::pc_t       update_pc;
    bp_pkg::br_type_e  update_br_type;
    bp_pkg::pc_t       update_target;
    logic              update_taken;
    bp_pkg::br_type_e  pred_type;
    logic              pred_taken;
    bp_pkg::pc_t       pred_target;
    bp_pkg::pc_t       next_pc;

    logic [31:0] rnd_state; // xorshift state
    int          checks;    // lookups compared so far

    ////////////////////////////////////////
    // dut and clock
    ////////////////////////////////////////

    branch_predictor #(
        .btb_depth (btb_depth),
        .pht_depth (pht_depth)
    ) i_dut (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_pc       (fetch_pc),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_br_type (update_br_type),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .pred_type      (pred_type),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .next_pc        (next_pc)
    );

    always #50 clk = ~clk; // 100 ns period

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // 13/17/5 xorshift step
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_type(input string name, input bp_pkg::br_type_e exp,
                              input bp_pkg::br_type_e act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERROR %0t %s expected %s actual %s",
                               $time, name, exp.name(), act.name()));
        end
    endtask

    task automatic check_pc(input string name, input bp_pkg::pc_t exp,
                            input bp_pkg::pc_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERROR %0t %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERROR %0t %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    // drive one cycle, then sit at the negedge after the sampling edge
    task automatic run_cycle(input bp_pkg::pc_t lpc, input logic upd_en,
                             input bp_pkg::pc_t upc, input bp_pkg::br_type_e utype,
                             input bp_pkg::pc_t utgt, input logic utk);
        @(posedge clk);
        fetch_pc       <= lpc;
        update_valid   <= upd_en; // single-cycle strobe
        update_pc      <= upc;
        update_br_type <= utype;
        update_target  <= utgt;
        update_taken   <= utk;
        @(posedge clk); // dut samples here
        update_valid   <= 1'b0;
        @(negedge clk); // outputs settled
    endtask

    task automatic check_lookup(input bp_pkg::br_type_e etype, input logic etk,
                                input bp_pkg::pc_t etgt, input bp_pkg::pc_t enext);
        check_type("pred_type", etype, pred_type);
        check_bit("pred_taken", etk, pred_taken);
        check_pc("pred_target", etgt, pred_target);
        check_pc("next_pc", enext, next_pc);
        checks++;
    endtask

    ////////////////////////////////////////
    // main flow
    ////////////////////////////////////////

    initial
    begin
        int                fd;
        int                lines;
        int                n;
        int                count;
        int                wait_cycles;
        string             line;
        byte               code;
        bp_pkg::pc_t       upc;
        bp_pkg::pc_t       utgt;
        bp_pkg::pc_t       lpc;
        bp_pkg::pc_t       etgt;
        bp_pkg::pc_t       enext;
        logic [1:0]        utype;
        logic [1:0]        etype;
        logic              utk;
        logic              etk;

        clk            = 1'b0;
        rstn           = 1'b0;
        fetch_pc       = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_br_type = bp_pkg::br_jump; // never br_none on the bus
        update_target  = '0;
        update_taken   = 1'b0;
        rnd_state      = 32'hcc2a_aae9;
        checks         = 0;

        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        wait_cycles = 0;
        while (rstn !== 1'b1)
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > reset_timeout)
            begin
                stop_run("timeout while waiting for reset release");
            end
        end

        fd = $fopen("verif/bp_tests.txt", "r");
        if (fd == 0)
        begin
            stop_run("could not open the tests file verif/bp_tests.txt");
        end

        lines = 0;
        while (!$feof(fd))
        begin
            lines++;
            if (lines > max_lines)
            begin
                stop_run("timeout while reading the tests file, too many lines");
            end
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
            begin
                continue; // comment or blank
            end
            case (line[0])
                "u":
                begin
                    n = $sscanf(line, "%c %h %h %h %h", code, upc, utype, utgt, utk);
                    if (n != 5)
                    begin
                        stop_run("malformed update record in the tests file");
                    end
                    run_cycle(fetch_pc, 1'b1, upc, bp_pkg::br_type_e'(utype), utgt, utk);
                end
                "l":
                begin
                    n = $sscanf(line, "%c %h %h %h %h %h", code, lpc, etype, etk,
                                etgt, enext);
                    if (n != 6)
                    begin
                        stop_run("malformed lookup record in the tests file");
                    end
                    run_cycle(lpc, 1'b0, update_pc, update_br_type, update_target, 1'b0);
                    check_lookup(bp_pkg::br_type_e'(etype), etk, etgt, enext);
                end
                "b":
                begin
                    // update and lookup sampled at the same edge
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", code, upc, utype,
                                utgt, utk, lpc, etype, etk, etgt, enext);
                    if (n != 10)
                    begin
                        stop_run("malformed same-edge record in the tests file");
                    end
                    run_cycle(lpc, 1'b1, upc, bp_pkg::br_type_e'(utype), utgt, utk);
                    check_lookup(bp_pkg::br_type_e'(etype), etk, etgt, enext);
                end
                "r":
                begin
                    n = $sscanf(line, "%c %d", code, count);
                    if (n != 2)
                    begin
                        stop_run("malformed random record in the tests file");
                    end
                    for (int i = 0; i < count; i++)
                    begin
                        rnd_state = xorshift(rnd_state);
                        lpc = rnd_state[29:0];
                        run_cycle(lpc, 1'b0, update_pc, update_br_type, update_target, 1'b0);
                        // empty table, so a miss falls through
                        check_lookup(bp_pkg::br_none, 1'b0, lpc, lpc + 30'd1);
                    end
                end
                default:
                begin
                    stop_run("unknown record kind in the tests file");
                end
            endcase
        end
        $fclose(fd);

        if (checks == 0)
        begin
            stop_run("no lookup was checked, the tests file held no lookups");
        end
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/bp_pkg.sv
logic/bp_update_if.sv
logic/sdp_ram.sv
logic/btb.sv
logic/pht.sv
logic/branch_predictor.sv
verif/tb_branch_predictor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

# compile from the project root so the tests file path resolves
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_branch_predictor -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log

# the log decides the result
grep -qs "^Test OK$" sim.log && exit 0 || exit 1

// ==== verif/bp_tests.txt ====
# u pc type target taken                              update only
# l pc type taken target next                         lookup and check
# b upc utype utarget utaken lpc type taken target next  same-edge update and lookup
# r count                                             random pcs expected to miss
# hex fields, type 0 none 1 cond 2 jump 3 call
#
# misses after reset
r 50
#
# unconditional hits
u 00000100 2 00000400 1
l 00000100 2 1 00000400 00000400
u 00000208 3 00001000 1
l 00000208 3 1 00001000 00001000
#
# conditional training, 410 shares the counter and btb index of 310
u 00000410 1 00000099 0
u 00000310 1 00000050 1
l 00000310 1 0 00000050 00000311
u 00000310 1 00000050 1
l 00000310 1 1 00000050 00000050
u 00000310 1 00000050 0
u 00000310 1 00000050 0
l 00000310 1 0 00000050 00000311
#
# saturation at the top
u 00000520 1 00000060 1
u 00000520 1 00000060 1
u 00000520 1 00000060 1
u 00000520 1 00000060 1
u 00000520 1 00000060 0
l 00000520 1 1 00000060 00000060
# saturation at the bottom
u 00000520 1 00000060 0
u 00000520 1 00000060 0
u 00000520 1 00000060 0
u 00000520 1 00000060 0
u 00000520 1 00000060 1
l 00000520 1 0 00000060 00000521
#
# alias 180 has the index of 100 and another tag
l 00000180 0 0 00000180 00000181
u 00000180 3 00000700 1
l 00000180 3 1 00000700 00000700
l 00000100 0 0 00000100 00000101
#
# same-edge lookups see old contents, next lookup sees new
b 00000208 2 00002000 1 00000208 3 1 00001000 00001000
l 00000208 2 1 00002000 00002000
b 00000520 1 00000060 1 00000520 1 0 00000060 00000521
l 00000520 1 1 00000060 00000060
b 00000a04 2 00000b00 1 00000a04 0 0 00000a04 00000a05
l 00000a04 2 1 00000b00 00000b00
